//--- Makefile
TOP := tb_dcache
RTL := design/cache_pkg.sv design/access_pkg.sv design/way_ram.sv \
       design/lru_dirty_table.sv design/line_access.sv design/writeback_unit.sv \
       design/dcache_ctrl.sv design/dcache_top.sv

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '=== PASS ==='

obj_dir/V$(TOP): dcache.f design/*.sv design/*.svh verif/*.sv
	verilator --binary --timing --assert --top-module $(TOP) -f dcache.f

lint:
	verilator --lint-only -Wall +incdir+design --top-module dcache_top $(RTL)

clean:
	rm -rf obj_dir

.PHONY: run lint clean

//--- dcache.f
+incdir+design
design/cache_pkg.sv
design/access_pkg.sv
design/way_ram.sv
design/lru_dirty_table.sv
design/line_access.sv
design/writeback_unit.sv
design/dcache_ctrl.sv
design/dcache_top.sv
verif/mem_model.sv
verif/tb_dcache.sv

//--- design/access_pkg.sv
`default_nettype none

package access_pkg;

    typedef logic [31:0] word_t;

    // access width, address must be aligned to it
    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } size_e;

    typedef enum logic {
        LOAD  = 1'b0,
        STORE = 1'b1
    } op_e;

endpackage

`default_nettype wire

//--- design/cache_pkg.sv
`default_nettype none

`include "dcache_config.svh"

package cache_pkg;

    typedef logic [`DC_ADDR_W-1:0] addr_t;

    typedef logic [`DC_INDEX_W-1:0] index_t;

    // tag is everything above index and line offset
    typedef logic [`DC_ADDR_W-`DC_INDEX_W-`DC_WORD_OFF_W-3:0] tag_t;

    // one full line, 32 bits per word
    typedef logic [(32 << `DC_WORD_OFF_W)-1:0] line_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tagv_t;

    typedef logic [$clog2(`DC_WAYS)-1:0] way_t;

endpackage

`default_nettype wire

//--- design/dcache_config.svh
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// byte address width
`define DC_ADDR_W 32

// 64 sets per way
`define DC_INDEX_W 6

// 16 words in a 64-byte line
`define DC_WORD_OFF_W 4

// two ways, the structure depends on it
`define DC_WAYS 2

`endif

//--- design/dcache_ctrl.sv
`default_nettype none

`include "dcache_config.svh"

module dcache_ctrl (
    input  wire                    clk,
    input  wire                    rstn,
    input  wire                    i_valid,
    input  wire access_pkg::op_e   i_op,
    input  wire cache_pkg::addr_t  i_addr,
    input  wire access_pkg::size_e i_size,
    input  wire                    i_signed,
    input  wire access_pkg::word_t i_wdata,
    output logic                   o_ready,
    output access_pkg::word_t      o_rdata,
    output cache_pkg::index_t      o_rindex,
    input  wire cache_pkg::line_t  i_data_rd0,
    input  wire cache_pkg::line_t  i_data_rd1,
    input  wire cache_pkg::tagv_t  i_tagv_rd0,
    input  wire cache_pkg::tagv_t  i_tagv_rd1,
    output logic [`DC_WAYS-1:0]    o_data_we,
    output logic [`DC_WAYS-1:0]    o_tagv_we,
    output cache_pkg::index_t      o_windex,
    output cache_pkg::line_t       o_wline,
    output cache_pkg::tagv_t       o_wtagv,
    output logic                   o_touch,
    output cache_pkg::way_t        o_touch_way,
    output logic                   o_dirty_we,
    output cache_pkg::way_t        o_dirty_way,
    output logic                   o_dirty_val,
    input  wire cache_pkg::way_t   i_victim,
    output cache_pkg::line_t       o_sel_line,
    output cache_pkg::addr_t       o_acc_addr,
    output access_pkg::size_e      o_acc_size,
    output logic                   o_acc_signed,
    output access_pkg::word_t      o_acc_wdata,
    input  wire access_pkg::word_t i_load,
    input  wire cache_pkg::line_t  i_merged,
    output logic                   o_wb_start,
    output logic                   o_wb_ack,
    output logic                   o_victim_valid,
    output cache_pkg::line_t       o_victim_line,
    output cache_pkg::addr_t       o_victim_addr,
    input  wire                    i_wb_done,
    output logic                   o_mem_rvalid,
    input  wire                    i_mem_rready,
    output cache_pkg::addr_t       o_mem_raddr,
    input  wire cache_pkg::line_t  i_mem_rdata
);

    localparam int OFF_W   = `DC_WORD_OFF_W + 2;
    localparam int TAG_LSB = OFF_W + `DC_INDEX_W;

    typedef enum logic [2:0] {IDLE, LOOKUP, MISS, REFILL, WAIT_WRITE} state_e;

    state_e              state, next_state;

    // request buffer
    access_pkg::op_e     req_op;
    cache_pkg::addr_t    req_addr;
    access_pkg::size_e   req_size;
    logic                req_signed;
    access_pkg::word_t   req_wdata;

    cache_pkg::line_t    ret_buf;
    cache_pkg::index_t   req_index;
    cache_pkg::tag_t     req_tag;
    logic [`DC_WAYS-1:0] hit;
    logic                cache_hit;
    cache_pkg::way_t     hit_way;
    cache_pkg::tagv_t    victim_tagv;

    assign req_index = req_addr[TAG_LSB-1:OFF_W];
    assign req_tag   = req_addr[`DC_ADDR_W-1:TAG_LSB];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && i_valid) begin
            req_op     <= i_op;
            req_addr   <= i_addr;
            req_size   <= i_size;
            req_signed <= i_signed;
            req_wdata  <= i_wdata;
        end
    end

    // return buffer holds the refill line until completion
    always_ff @(posedge clk) begin
        if (o_mem_rvalid && i_mem_rready) begin
            ret_buf <= i_mem_rdata;
        end
    end

    assign hit[0]      = i_tagv_rd0.valid && (i_tagv_rd0.tag == req_tag);
    assign hit[1]      = i_tagv_rd1.valid && (i_tagv_rd1.tag == req_tag);
    assign cache_hit   = |hit;
    assign hit_way     = cache_pkg::way_t'(hit[1]);
    assign victim_tagv = i_victim ? i_tagv_rd1 : i_tagv_rd0;

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (i_valid) begin
                    next_state = LOOKUP;
                end
            end
            LOOKUP: next_state = cache_hit ? IDLE : MISS;
            MISS: begin
                if (i_mem_rready) begin
                    next_state = REFILL;
                end
            end
            REFILL: next_state = WAIT_WRITE;
            WAIT_WRITE: begin
                if (i_wb_done) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    // index from the pipeline while idle so lookup data lands in LOOKUP
    assign o_rindex = (state == IDLE) ? i_addr[TAG_LSB-1:OFF_W] : req_index;
    assign o_windex = req_index;

    // hit line during lookup, refill line afterwards
    assign o_sel_line = (state == LOOKUP) ? (hit[1] ? i_data_rd1 : i_data_rd0) : ret_buf;
    assign o_wline    = (req_op == access_pkg::STORE) ? i_merged : o_sel_line;
    assign o_wtagv    = {1'b1, req_tag};

    assign o_acc_addr   = req_addr;
    assign o_acc_size   = req_size;
    assign o_acc_signed = req_signed;
    assign o_acc_wdata  = req_wdata;

    always_comb begin
        o_data_we   = '0;
        o_tagv_we   = '0;
        o_touch     = 1'b0;
        o_touch_way = hit_way;
        o_dirty_we  = 1'b0;
        o_dirty_way = hit_way;
        o_dirty_val = 1'b1;
        case (state)
            LOOKUP: begin
                if (cache_hit) begin
                    o_touch = 1'b1;
                    if (req_op == access_pkg::STORE) begin
                        o_data_we[hit_way] = 1'b1;
                        o_dirty_we         = 1'b1;
                    end
                end
            end
            REFILL: begin
                // line, tag, LRU and dirty all land in this cycle
                o_data_we[i_victim] = 1'b1;
                o_tagv_we[i_victim] = 1'b1;
                o_touch             = 1'b1;
                o_touch_way         = i_victim;
                o_dirty_we          = 1'b1;
                o_dirty_way         = i_victim;
                o_dirty_val         = (req_op == access_pkg::STORE);
            end
            default: ;
        endcase
    end

    assign o_ready = (state == LOOKUP && cache_hit) || (state == WAIT_WRITE && i_wb_done);
    assign o_rdata = i_load;

    assign o_wb_start     = (state == LOOKUP) && !cache_hit;
    assign o_wb_ack       = (state == WAIT_WRITE) && i_wb_done;
    assign o_victim_valid = victim_tagv.valid;
    assign o_victim_line  = i_victim ? i_data_rd1 : i_data_rd0;
    assign o_victim_addr  = {victim_tagv.tag, req_index, {OFF_W{1'b0}}};

    assign o_mem_rvalid = (state == MISS);
    assign o_mem_raddr  = {req_tag, req_index, {OFF_W{1'b0}}};

    // a line is never resident in both ways of a set
    a_one_hit: assert property (@(posedge clk) disable iff (!rstn)
        (state == LOOKUP) |-> $onehot0(hit));

    a_read_hold: assert property (@(posedge clk) disable iff (!rstn)
        o_mem_rvalid && !i_mem_rready |=> o_mem_rvalid && $stable(o_mem_raddr));

endmodule

`default_nettype wire

//--- design/dcache_top.sv
`default_nettype none

`include "dcache_config.svh"

module dcache_top (
    input  wire                    clk,
    input  wire                    rstn,
    input  wire                    i_valid,
    input  wire access_pkg::op_e   i_op,
    input  wire cache_pkg::addr_t  i_addr,
    input  wire access_pkg::size_e i_size,
    input  wire                    i_signed,
    input  wire access_pkg::word_t i_wdata,
    output logic                   o_ready,
    output access_pkg::word_t      o_rdata,
    output logic                   o_mem_rvalid,
    input  wire                    i_mem_rready,
    output cache_pkg::addr_t       o_mem_raddr,
    input  wire cache_pkg::line_t  i_mem_rdata,
    output logic                   o_mem_wvalid,
    input  wire                    i_mem_wready,
    output cache_pkg::addr_t       o_mem_waddr,
    output cache_pkg::line_t       o_mem_wdata
);

    cache_pkg::index_t   rindex, windex;
    cache_pkg::line_t    data_rd0, data_rd1, wline, sel_line, merged;
    cache_pkg::tagv_t    tagv_rd0, tagv_rd1, wtagv;
    logic [`DC_WAYS-1:0] data_we, tagv_we;
    logic                touch, dirty_we, dirty_val, victim_dirty;
    cache_pkg::way_t     touch_way, dirty_way, victim;
    cache_pkg::addr_t    acc_addr, victim_addr;
    access_pkg::size_e   acc_size;
    logic                acc_signed;
    access_pkg::word_t   acc_wdata, load;
    logic                wb_start, wb_ack, wb_done, victim_valid;
    cache_pkg::line_t    victim_line;

    dcache_ctrl dcache_ctrl_inst (
        .clk, .rstn, .i_valid, .i_op, .i_addr, .i_size, .i_signed, .i_wdata,
        .o_ready, .o_rdata,
        .o_rindex(rindex), .i_data_rd0(data_rd0), .i_data_rd1(data_rd1),
        .i_tagv_rd0(tagv_rd0), .i_tagv_rd1(tagv_rd1),
        .o_data_we(data_we), .o_tagv_we(tagv_we), .o_windex(windex),
        .o_wline(wline), .o_wtagv(wtagv),
        .o_touch(touch), .o_touch_way(touch_way), .o_dirty_we(dirty_we),
        .o_dirty_way(dirty_way), .o_dirty_val(dirty_val), .i_victim(victim),
        .o_sel_line(sel_line), .o_acc_addr(acc_addr), .o_acc_size(acc_size),
        .o_acc_signed(acc_signed), .o_acc_wdata(acc_wdata),
        .i_load(load), .i_merged(merged),
        .o_wb_start(wb_start), .o_wb_ack(wb_ack), .o_victim_valid(victim_valid),
        .o_victim_line(victim_line), .o_victim_addr(victim_addr), .i_wb_done(wb_done),
        .o_mem_rvalid, .i_mem_rready, .o_mem_raddr, .i_mem_rdata
    );

    // data arrays carry no reset
    way_ram #(.entry_t(cache_pkg::line_t)) data0 (
        .clk, .rstn(1'b1), .i_raddr(rindex), .o_rdata(data_rd0),
        .i_we(data_we[0]), .i_waddr(windex), .i_wdata(wline)
    );

    way_ram #(.entry_t(cache_pkg::line_t)) data1 (
        .clk, .rstn(1'b1), .i_raddr(rindex), .o_rdata(data_rd1),
        .i_we(data_we[1]), .i_waddr(windex), .i_wdata(wline)
    );

    way_ram #(.entry_t(cache_pkg::tagv_t)) tagv0 (
        .clk, .rstn, .i_raddr(rindex), .o_rdata(tagv_rd0),
        .i_we(tagv_we[0]), .i_waddr(windex), .i_wdata(wtagv)
    );

    way_ram #(.entry_t(cache_pkg::tagv_t)) tagv1 (
        .clk, .rstn, .i_raddr(rindex), .o_rdata(tagv_rd1),
        .i_we(tagv_we[1]), .i_waddr(windex), .i_wdata(wtagv)
    );

    lru_dirty_table lru_dirty_table_inst (
        .clk, .rstn, .i_index(windex),
        .i_touch(touch), .i_touch_way(touch_way),
        .i_dirty_we(dirty_we), .i_dirty_way(dirty_way), .i_dirty_val(dirty_val),
        .o_victim(victim), .o_victim_dirty(victim_dirty)
    );

    line_access line_access_inst (
        .i_line(sel_line), .i_addr(acc_addr), .i_size(acc_size),
        .i_signed(acc_signed), .i_wdata(acc_wdata),
        .o_load(load), .o_merged(merged)
    );

    writeback_unit writeback_unit_inst (
        .clk, .rstn, .i_start(wb_start),
        .i_victim_valid(victim_valid), .i_victim_dirty(victim_dirty),
        .i_victim_line(victim_line), .i_victim_addr(victim_addr),
        .i_ack(wb_ack), .o_done(wb_done),
        .o_mem_wvalid, .i_mem_wready, .o_mem_waddr, .o_mem_wdata
    );

endmodule

`default_nettype wire

//--- design/line_access.sv
`default_nettype none

`include "dcache_config.svh"

module line_access (
    input  wire cache_pkg::line_t   i_line,
    input  wire cache_pkg::addr_t   i_addr,
    input  wire access_pkg::size_e  i_size,
    input  wire                     i_signed,
    input  wire access_pkg::word_t  i_wdata,
    output access_pkg::word_t       o_load,
    output cache_pkg::line_t        o_merged
);

    logic [`DC_WORD_OFF_W-1:0] word_off;
    access_pkg::word_t         sel_word;
    access_pkg::word_t         lane_data;
    logic [7:0]                byte_val;
    logic [15:0]               half_val;
    logic [3:0]                lanes;

    assign word_off = i_addr[`DC_WORD_OFF_W+1:2];
    assign sel_word = i_line[{word_off, 5'b0} +: 32];
    assign byte_val = sel_word[{i_addr[1:0], 3'b0} +: 8];
    assign half_val = sel_word[{i_addr[1], 4'b0} +: 16];

    always_comb begin
        case (i_size)
            access_pkg::BYTE: o_load = {{24{byte_val[7] & i_signed}}, byte_val};
            access_pkg::HALF: o_load = {{16{half_val[15] & i_signed}}, half_val};
            default:          o_load = sel_word;
        endcase
    end

    // byte lanes of the store, data replicated onto them
    always_comb begin
        case (i_size)
            access_pkg::BYTE: begin
                lanes     = 4'b0001 << i_addr[1:0];
                lane_data = {4{i_wdata[7:0]}};
            end
            access_pkg::HALF: begin
                lanes     = 4'b0011 << {i_addr[1], 1'b0};
                lane_data = {2{i_wdata[15:0]}};
            end
            default: begin
                lanes     = 4'b1111;
                lane_data = i_wdata;
            end
        endcase
    end

    always_comb begin
        o_merged = i_line;
        for (int b = 0; b < 4; b++) begin
            if (lanes[b]) begin
                o_merged[{word_off, 5'b0} + 8 * b +: 8] = lane_data[8 * b +: 8];
            end
        end
    end

endmodule

`default_nettype wire

//--- design/lru_dirty_table.sv
`default_nettype none

`include "dcache_config.svh"

module lru_dirty_table (
    input  wire                    clk,
    input  wire                    rstn,
    input  wire cache_pkg::index_t i_index,
    input  wire                    i_touch,
    input  wire cache_pkg::way_t   i_touch_way,
    input  wire                    i_dirty_we,
    input  wire cache_pkg::way_t   i_dirty_way,
    input  wire                    i_dirty_val,
    output cache_pkg::way_t        o_victim,
    output logic                   o_victim_dirty
);

    localparam int SETS = 1 << `DC_INDEX_W;

    // way used last in each set
    logic [SETS-1:0]                lru;
    logic [SETS-1:0][`DC_WAYS-1:0]  dirty;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lru   <= '0;
            dirty <= '0;
        end else begin
            if (i_touch) begin
                lru[i_index] <= i_touch_way;
            end
            if (i_dirty_we) begin
                dirty[i_index][i_dirty_way] <= i_dirty_val;
            end
        end
    end

    // the other way is the least recently used one
    assign o_victim       = cache_pkg::way_t'(~lru[i_index]);
    assign o_victim_dirty = dirty[i_index][o_victim];

    // with two ways only an unknown way number falls outside the table
    a_way_range: assert property (@(posedge clk) disable iff (!rstn)
        (!i_touch || !$isunknown(i_touch_way)) &&
        (!i_dirty_we || !$isunknown(i_dirty_way)));

endmodule

`default_nettype wire

//--- design/way_ram.sv
`default_nettype none

`include "dcache_config.svh"

module way_ram #(
    parameter type entry_t = cache_pkg::line_t,
    parameter int  DEPTH   = 1 << `DC_INDEX_W
) (
    input  wire                      clk,
    input  wire                      rstn,
    input  wire cache_pkg::index_t   i_raddr,
    output entry_t                   o_rdata,
    input  wire                      i_we,
    input  wire cache_pkg::index_t   i_waddr,
    input  wire entry_t              i_wdata
);

    entry_t mem [DEPTH];

    // reset loop clears every entry, data arrays tie rstn high
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // registered read, data one cycle after the index
    always_ff @(posedge clk) begin
        o_rdata <= mem[i_raddr];
    end

endmodule

`default_nettype wire

//--- design/writeback_unit.sv
`default_nettype none

module writeback_unit (
    input  wire                   clk,
    input  wire                   rstn,
    input  wire                   i_start,
    input  wire                   i_victim_valid,
    input  wire                   i_victim_dirty,
    input  wire cache_pkg::line_t i_victim_line,
    input  wire cache_pkg::addr_t i_victim_addr,
    input  wire                   i_ack,
    output logic                  o_done,
    output logic                  o_mem_wvalid,
    input  wire                   i_mem_wready,
    output cache_pkg::addr_t      o_mem_waddr,
    output cache_pkg::line_t      o_mem_wdata
);

    typedef enum logic [1:0] {INIT, WRITE, FINISH} wstate_e;

    wstate_e          state, next_state;
    cache_pkg::line_t wbuf;
    cache_pkg::addr_t wbuf_addr;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= INIT;
        end else begin
            state <= next_state;
        end
    end

    // victim captured at start, the RAM may change afterwards
    always_ff @(posedge clk) begin
        if (state == INIT && i_start) begin
            wbuf      <= i_victim_line;
            wbuf_addr <= i_victim_addr;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            INIT: begin
                if (i_start) begin
                    // clean or empty victims skip the write
                    next_state = (i_victim_valid && i_victim_dirty) ? WRITE : FINISH;
                end
            end
            WRITE: begin
                if (i_mem_wready) begin
                    next_state = FINISH;
                end
            end
            FINISH: begin
                if (i_ack) begin
                    next_state = INIT;
                end
            end
            default: next_state = INIT;
        endcase
    end

    assign o_mem_wvalid = (state == WRITE);
    assign o_done       = (state == FINISH);
    assign o_mem_waddr  = wbuf_addr;
    assign o_mem_wdata  = wbuf;

    a_write_hold: assert property (@(posedge clk) disable iff (!rstn)
        o_mem_wvalid && !i_mem_wready |=>
        o_mem_wvalid && $stable(o_mem_waddr) && $stable(o_mem_wdata));

endmodule

`default_nettype wire

//--- verif/mem_model.sv
`default_nettype none

module mem_model (
    input  wire                   clk,
    input  wire                   rstn,
    input  wire                   i_mem_rvalid,
    output logic                  o_mem_rready,
    input  wire cache_pkg::addr_t i_mem_raddr,
    output cache_pkg::line_t      o_mem_rdata,
    input  wire                   i_mem_wvalid,
    output logic                  o_mem_wready,
    input  wire cache_pkg::addr_t i_mem_waddr,
    input  wire cache_pkg::line_t i_mem_wdata,
    input  wire                   i_note_store,
    input  wire cache_pkg::addr_t i_note_addr
);

    localparam int BYTES = 65536;
    localparam int LINES = BYTES / 64;

    // 64 KB backing store, byte addressed
    logic [7:0]       mem [BYTES];
    // line was stored to since its last refill
    logic [LINES-1:0] stored;
    int               rwait;
    int               wwait;

    function automatic cache_pkg::line_t read_line(cache_pkg::addr_t addr);
        cache_pkg::line_t line;
        for (int k = 0; k < 64; k++) begin
            line[8 * k +: 8] = mem[{addr[15:6], 6'(k)}];
        end
        return line;
    endfunction

    initial begin
        o_mem_rready = 1'b0;
        o_mem_wready = 1'b0;
        o_mem_rdata  = '0;
        rwait        = 0;
        wwait        = 0;
        // every byte depends on all 16 address bits
        for (int a = 0; a < BYTES; a++) begin
            mem[a] = 8'(a ^ ((a >> 8) * 29) ^ 8'h3c);
        end
    end

    // ready is raised 0 to 3 cycles after valid, dropped after the handshake
    always @(negedge clk) begin
        if (!rstn) begin
            o_mem_rready = 1'b0;
            o_mem_wready = 1'b0;
            rwait        = $urandom_range(3);
            wwait        = $urandom_range(3);
        end else begin
            if (o_mem_rready) begin
                o_mem_rready = 1'b0;
                rwait        = $urandom_range(3);
            end else if (i_mem_rvalid) begin
                if (rwait == 0) begin
                    o_mem_rready = 1'b1;
                    o_mem_rdata  = read_line(i_mem_raddr);
                end else begin
                    rwait--;
                end
            end
            if (o_mem_wready) begin
                o_mem_wready = 1'b0;
                wwait        = $urandom_range(3);
            end else if (i_mem_wvalid) begin
                if (wwait == 0) begin
                    o_mem_wready = 1'b1;
                end else begin
                    wwait--;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (!rstn) begin
            stored <= '0;
        end else begin
            if (i_mem_wvalid && o_mem_wready) begin
                for (int k = 0; k < 64; k++) begin
                    mem[{i_mem_waddr[15:6], 6'(k)}] = i_mem_wdata[8 * k +: 8];
                end
            end
            // a refill starts a fresh clean copy
            if (i_mem_rvalid && o_mem_rready) begin
                stored[i_mem_raddr[15:6]] <= 1'b0;
            end
            if (i_note_store) begin
                stored[i_note_addr[15:6]] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/tb_dcache.sv
`default_nettype none

module tb_dcache;

    localparam int NUM_REQ   = 2000;
    localparam int MAX_CYCLE = NUM_REQ * 40;
    localparam int MEM_BYTES = 65536;

    logic              clk;
    logic              rstn;
    logic              valid;
    access_pkg::op_e   op;
    cache_pkg::addr_t  addr;
    access_pkg::size_e size;
    logic              sgn;
    access_pkg::word_t wdata;
    logic              ready;
    access_pkg::word_t rdata;
    logic              mem_rvalid;
    logic              mem_rready;
    cache_pkg::addr_t  mem_raddr;
    cache_pkg::line_t  mem_rdata;
    logic              mem_wvalid;
    logic              mem_wready;
    cache_pkg::addr_t  mem_waddr;
    cache_pkg::line_t  mem_wdata;
    logic              note_store;
    cache_pkg::addr_t  note_addr;

    // reference copy of memory as the pipeline sees it
    logic [7:0]        shadow [MEM_BYTES];
    logic [1023:0]     seen_line;
    // address of the access in progress
    cache_pkg::addr_t  cur_addr;
    int                cycles     = 0;
    int                done_count = 0;

    dcache_top dcache_top_inst (
        .clk, .rstn,
        .i_valid(valid), .i_op(op), .i_addr(addr), .i_size(size),
        .i_signed(sgn), .i_wdata(wdata), .o_ready(ready), .o_rdata(rdata),
        .o_mem_rvalid(mem_rvalid), .i_mem_rready(mem_rready),
        .o_mem_raddr(mem_raddr), .i_mem_rdata(mem_rdata),
        .o_mem_wvalid(mem_wvalid), .i_mem_wready(mem_wready),
        .o_mem_waddr(mem_waddr), .o_mem_wdata(mem_wdata)
    );

    mem_model mem_model_inst (
        .clk, .rstn,
        .i_mem_rvalid(mem_rvalid), .o_mem_rready(mem_rready),
        .i_mem_raddr(mem_raddr), .o_mem_rdata(mem_rdata),
        .i_mem_wvalid(mem_wvalid), .o_mem_wready(mem_wready),
        .i_mem_waddr(mem_waddr), .i_mem_wdata(mem_wdata),
        .i_note_store(note_store), .i_note_addr(note_addr)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    task automatic stop_on_error();
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_load(string name, access_pkg::word_t got, access_pkg::word_t exp);
        if (got !== exp) begin
            $display("ERR time %0t %s got %h expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_line(string name, cache_pkg::line_t got, cache_pkg::line_t exp);
        if (got !== exp) begin
            $display("ERR time %0t %s got %h expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_addr(string name, cache_pkg::addr_t got, cache_pkg::addr_t exp);
        if (got !== exp) begin
            $display("ERR time %0t %s got %h expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    // three tags over four sets, offsets spread across the line
    function automatic cache_pkg::addr_t pick_addr(access_pkg::size_e sz);
        logic [19:0] tag;
        logic [5:0]  index;
        logic [3:0]  word;
        logic [1:0]  sub;
        tag   = 20'(1 + 5 * $urandom_range(2));
        index = 6'(21 * $urandom_range(3));
        word  = 4'(5 * $urandom_range(3));
        sub   = 2'($urandom_range(3));
        case (sz)
            access_pkg::HALF: sub[0] = 1'b0;
            access_pkg::WORD: sub = 2'b00;
            default: ;
        endcase
        return {tag, index, word, sub};
    endfunction

    // little endian, sign taken from the top byte of the access
    function automatic access_pkg::word_t expect_load(cache_pkg::addr_t a,
                                                      access_pkg::size_e sz, logic sg);
        int base;
        base = int'(a[15:0]);
        case (sz)
            access_pkg::BYTE: return {{24{sg & shadow[base][7]}}, shadow[base]};
            access_pkg::HALF: return {{16{sg & shadow[base + 1][7]}},
                                      shadow[base + 1], shadow[base]};
            default:          return {shadow[base + 3], shadow[base + 2],
                                      shadow[base + 1], shadow[base]};
        endcase
    endfunction

    function automatic void apply_store(cache_pkg::addr_t a, access_pkg::size_e sz,
                                        access_pkg::word_t d);
        int base;
        int count;
        base  = int'(a[15:0]);
        count = (sz == access_pkg::BYTE) ? 1 : (sz == access_pkg::HALF) ? 2 : 4;
        for (int k = 0; k < count; k++) begin
            shadow[base + k] = d[8 * k +: 8];
        end
    endfunction

    function automatic cache_pkg::line_t model_line(cache_pkg::addr_t a);
        cache_pkg::line_t line;
        for (int k = 0; k < 64; k++) begin
            line[8 * k +: 8] = shadow[{a[15:6], 6'(k)}];
        end
        return line;
    endfunction

    // starts and ends on a falling edge
    task automatic run_access(access_pkg::op_e a_op, cache_pkg::addr_t a_addr,
                              access_pkg::size_e a_size, logic a_sgn,
                              access_pkg::word_t a_wdata);
        logic saw_rvalid;
        int   line;
        line       = int'(a_addr[15:6]);
        saw_rvalid = 1'b0;
        cur_addr   = a_addr;
        valid      = 1'b1;
        op         = a_op;
        addr       = a_addr;
        size       = a_size;
        sgn        = a_sgn;
        wdata      = a_wdata;
        do begin
            @(negedge clk);
            if (mem_rvalid) begin
                saw_rvalid = 1'b1;
                // refill reads the line of the request
                check_addr("o_mem_raddr", mem_raddr, {a_addr[31:6], 6'b0});
            end
        end while (!ready);
        if (!seen_line[line] && !saw_rvalid) begin
            $display("first access to line %h completed without a memory read", a_addr);
            stop_on_error();
        end
        seen_line[line] = 1'b1;
        if (a_op == access_pkg::LOAD) begin
            check_load("o_rdata", rdata, expect_load(a_addr, a_size, a_sgn));
        end else begin
            apply_store(a_addr, a_size, a_wdata);
            note_store = 1'b1;
            note_addr  = a_addr;
        end
        done_count++;
        @(negedge clk);
        note_store = 1'b0;
        valid      = 1'b0;
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLE) begin
            $display("timeout after %0d cycles with %0d of %0d accesses done",
                     cycles, done_count, NUM_REQ);
            stop_on_error();
        end
    end

    // write port handshake, checked against the reference copy
    always @(posedge clk) begin
        if (rstn && mem_wvalid && mem_wready) begin
            if (!mem_model_inst.stored[mem_waddr[15:6]]) begin
                $display("line %h written back without a store since its refill", mem_waddr);
                stop_on_error();
            end
            // victim is a whole line in the set of the request
            check_addr("o_mem_waddr", {20'b0, mem_waddr[11:0]},
                       {20'b0, cur_addr[11:6], 6'b0});
            check_line("o_mem_wdata", mem_wdata, model_line(mem_waddr));
        end
    end

    initial begin
        access_pkg::op_e   r_op;
        access_pkg::size_e r_size;
        cache_pkg::addr_t  r_addr;
        logic              r_sgn;
        access_pkg::word_t r_wdata;
        void'($urandom(32'hb88d));
        rstn       = 1'b0;
        valid      = 1'b0;
        op         = access_pkg::LOAD;
        addr       = '0;
        size       = access_pkg::WORD;
        sgn        = 1'b0;
        wdata      = '0;
        note_store = 1'b0;
        note_addr  = '0;
        seen_line  = '0;
        cur_addr   = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        if (ready || mem_rvalid || mem_wvalid) begin
            $display("o_ready or a memory valid is high right after reset");
            stop_on_error();
        end
        for (int a = 0; a < MEM_BYTES; a++) begin
            shadow[a] = mem_model_inst.mem[a];
        end
        for (int n = 0; n < NUM_REQ; n++) begin
            r_op    = ($urandom_range(1) == 1) ? access_pkg::STORE : access_pkg::LOAD;
            r_size  = access_pkg::size_e'(2'($urandom_range(2)));
            r_sgn   = 1'($urandom_range(1));
            r_wdata = $urandom();
            r_addr  = pick_addr(r_size);
            run_access(r_op, r_addr, r_size, r_sgn, r_wdata);
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire
